/* rtl/alu_pkg.sv */
package alu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths

    localparam int DATA_WIDTH     = 32;
    localparam int PC_WIDTH       = 32;
    localparam int OFFSET_WIDTH   = 16;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int INSTR_ID_WIDTH = 6;

    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [PC_WIDTH-1:0]       pc_t;
    typedef logic [OFFSET_WIDTH-1:0]   offset_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [INSTR_ID_WIDTH-1:0] instr_id_t;

    //////////////////////////////////////////////////////////////////////
    // Opcodes

    // Grouped by class in the upper bits
    typedef enum logic [5:0] {
        ADD  = 6'h00,
        SUB  = 6'h01,
        ADDI = 6'h02,
        SUBI = 6'h03,
        SLL  = 6'h04,
        SRL  = 6'h05,
        MOV  = 6'h06,
        NOP  = 6'h07,
        LDW  = 6'h10,
        LDB  = 6'h11,
        STW  = 6'h12,
        STB  = 6'h13,
        BEQ  = 6'h30,
        BNE  = 6'h31,
        BLT  = 6'h32,
        BGT  = 6'h33,
        BLE  = 6'h34,
        BGE  = 6'h35,
        JUMP = 6'h38
    } opcode_e;

    //////////////////////////////////////////////////////////////////////
    // Opcode classes

    function automatic logic is_mem_op(input opcode_e op);
        return op inside {LDW, LDB, STW, STB};
    endfunction

    function automatic logic is_store_op(input opcode_e op);
        return op inside {STW, STB};
    endfunction

    function automatic logic is_byte_op(input opcode_e op);
        return op inside {LDB, STB};
    endfunction

    // Instructions that write the register file
    function automatic logic writes_reg(input opcode_e op);
        return op inside {ADD, SUB, ADDI, SUBI, SLL, SRL, MOV};
    endfunction

endpackage

/* rtl/alu_datapath.sv */
`timescale 1ns/1ns

module alu_datapath
(
    input  alu_pkg::opcode_e opcode,
    input  alu_pkg::data_t   ra_data,
    input  alu_pkg::data_t   rb_data,
    input  alu_pkg::offset_t offset,

    output alu_pkg::data_t   result,
    output logic             overflow,
    output alu_pkg::data_t   mem_addr
);

    import alu_pkg::*;

    // Immediate is unsigned
    data_t offset_ext;

    // One extra bit to catch carry and borrow
    logic [DATA_WIDTH:0] add_sum;
    logic [DATA_WIDTH:0] addi_sum;
    logic [DATA_WIDTH:0] subi_diff;
    logic [DATA_WIDTH:0] addr_sum;

    data_t mem_base;
    data_t sll_lost;

    assign offset_ext = {{(DATA_WIDTH-OFFSET_WIDTH){1'b0}}, offset};

    assign add_sum   = {1'b0, ra_data} + {1'b0, rb_data};
    assign addi_sum  = {1'b0, ra_data} + {1'b0, offset_ext};
    assign subi_diff = {1'b0, ra_data} - {1'b0, offset_ext};

    // Bits of ra that fall off the top on a left shift
    assign sll_lost = ra_data & ~({DATA_WIDTH{1'b1}} >> offset);

    //////////////////////////////////////////////////////////////////////
    // Memory address

    // Loads index off ra, stores off rb (ra holds the store data)
    assign mem_base = is_store_op(opcode) ? rb_data : ra_data;
    assign addr_sum = {1'b0, mem_base} + {1'b0, offset_ext};
    assign mem_addr = addr_sum[DATA_WIDTH-1:0];

    //////////////////////////////////////////////////////////////////////
    // Result and overflow

    always_comb
    begin
        result   = '0;
        overflow = 1'b0;

        case (opcode)
            ADD:
            begin
                result   = add_sum[DATA_WIDTH-1:0];
                overflow = add_sum[DATA_WIDTH];
            end
            SUB:
            begin
                // Wraps silently
                result = ra_data - rb_data;
            end
            ADDI:
            begin
                result   = addi_sum[DATA_WIDTH-1:0];
                overflow = addi_sum[DATA_WIDTH];
            end
            SUBI:
            begin
                result   = subi_diff[DATA_WIDTH-1:0];
                overflow = subi_diff[DATA_WIDTH];
            end
            SLL:
            begin
                result   = ra_data << offset;
                overflow = |sll_lost;
            end
            SRL:
            begin
                result = ra_data >> offset;
            end
            MOV:
            begin
                result = ra_data;
            end
            LDW, LDB, STW, STB:
            begin
                overflow = addr_sum[DATA_WIDTH];
            end
            default:
            begin
                // NOP and branches produce no value
                result = '0;
            end
        endcase
    end

endmodule

/* rtl/branch_resolve.sv */
`timescale 1ns/1ns

module branch_resolve
(
    input  alu_pkg::opcode_e opcode,
    input  alu_pkg::data_t   ra_data,
    input  alu_pkg::data_t   rb_data,
    input  alu_pkg::offset_t offset,

    output logic             branch_taken,
    output alu_pkg::pc_t     branch_target
);

    import alu_pkg::*;

    // Absolute target, taken straight from the immediate
    assign branch_target = {{(PC_WIDTH-OFFSET_WIDTH){1'b0}}, offset};

    //////////////////////////////////////////////////////////////////////
    // Condition evaluation

    // All comparisons unsigned
    always_comb
    begin
        case (opcode)
            BEQ:     branch_taken = (ra_data == rb_data);
            BNE:     branch_taken = (ra_data != rb_data);
            BLT:     branch_taken = (ra_data <  rb_data);
            BGT:     branch_taken = (ra_data >  rb_data);
            BLE:     branch_taken = (ra_data <= rb_data);
            BGE:     branch_taken = (ra_data >= rb_data);
            JUMP:    branch_taken = 1'b1;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

/* rtl/alu_dispatch.sv */
`timescale 1ns/1ns

module alu_dispatch
(
    input  logic               clock,
    input  logic               rst_n,
    input  logic               flush,

    // Request fields
    input  logic               req_valid,
    input  alu_pkg::opcode_e   opcode,
    input  alu_pkg::reg_addr_t rd_addr,
    input  alu_pkg::instr_id_t instr_id,
    input  alu_pkg::pc_t       pc,
    input  alu_pkg::data_t     ra_data,
    input  alu_pkg::data_t     rb_data,

    // From datapath and branch unit
    input  alu_pkg::data_t     result,
    input  logic               overflow,
    input  alu_pkg::data_t     mem_addr,
    input  logic               branch_taken,
    input  alu_pkg::pc_t       branch_target,

    // Data cache request
    output logic               dcache_valid,
    output alu_pkg::data_t     dcache_addr,
    output alu_pkg::data_t     dcache_data,
    output logic               dcache_is_store,
    output logic               dcache_byte,
    output alu_pkg::instr_id_t dcache_instr_id,

    // Write-back request
    output logic               wb_valid,
    output alu_pkg::instr_id_t wb_instr_id,
    output alu_pkg::pc_t       wb_pc,
    output logic               wb_rf_wen,
    output alu_pkg::reg_addr_t wb_rf_dest,
    output alu_pkg::data_t     wb_rf_data,
    output logic               wb_xcpt_overflow,

    // Redirect to fetch
    output logic               take_branch,
    output alu_pkg::pc_t       branch_pc
);

    import alu_pkg::*;

    logic accept;
    logic mem_ok;

    assign accept = req_valid && !flush;

    // Overflowing memory ops are reported through write-back instead
    assign mem_ok = is_mem_op(opcode) && !overflow;

    //////////////////////////////////////////////////////////////////////
    // Valid pulses

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dcache_valid <= 1'b0;
            wb_valid     <= 1'b0;
            take_branch  <= 1'b0;
        end
        else
        begin
            dcache_valid <= accept && mem_ok;
            wb_valid     <= accept && !mem_ok;
            take_branch  <= accept && branch_taken;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Payload

    always_ff @(posedge clock)
    begin
        if (req_valid)
        begin
            dcache_addr     <= mem_addr;
            // Store data comes from ra, loads just carry rb along
            dcache_data     <= is_store_op(opcode) ? ra_data : rb_data;
            dcache_is_store <= is_store_op(opcode);
            dcache_byte     <= is_byte_op(opcode);
            dcache_instr_id <= instr_id;

            wb_instr_id      <= instr_id;
            wb_pc            <= pc;
            wb_rf_wen        <= writes_reg(opcode) && !overflow;
            wb_rf_dest       <= rd_addr;
            wb_rf_data       <= result;
            wb_xcpt_overflow <= overflow;

            branch_pc <= branch_target;
        end
    end

endmodule

/* rtl/alu_top.sv */
`timescale 1ns/1ns

module alu_top
(
    input  logic               clock,
    input  logic               rst_n,
    input  logic               flush,

    // Request from decode
    input  logic               req_valid,
    input  alu_pkg::opcode_e   req_opcode,
    input  alu_pkg::reg_addr_t req_rd_addr,
    input  alu_pkg::data_t     req_ra_data,
    input  alu_pkg::data_t     req_rb_data,
    input  alu_pkg::offset_t   req_offset,
    input  alu_pkg::pc_t       req_pc,
    input  alu_pkg::instr_id_t req_instr_id,

    // Data cache request
    output logic               dcache_valid,
    output alu_pkg::data_t     dcache_addr,
    output alu_pkg::data_t     dcache_data,
    output logic               dcache_is_store,
    output logic               dcache_byte,
    output alu_pkg::instr_id_t dcache_instr_id,

    // Write-back request
    output logic               wb_valid,
    output alu_pkg::instr_id_t wb_instr_id,
    output alu_pkg::pc_t       wb_pc,
    output logic               wb_rf_wen,
    output alu_pkg::reg_addr_t wb_rf_dest,
    output alu_pkg::data_t     wb_rf_data,
    output logic               wb_xcpt_overflow,

    // Redirect to fetch
    output logic               take_branch,
    output alu_pkg::pc_t       branch_pc
);

    import alu_pkg::*;

    data_t result;
    logic  overflow;
    data_t mem_addr;
    logic  branch_taken;
    pc_t   branch_target;

    //////////////////////////////////////////////////////////////////////
    // Combinational units, side by side

    alu_datapath u_alu_datapath
    (
        .opcode   (req_opcode),
        .ra_data  (req_ra_data),
        .rb_data  (req_rb_data),
        .offset   (req_offset),
        .result   (result),
        .overflow (overflow),
        .mem_addr (mem_addr)
    );

    branch_resolve u_branch_resolve
    (
        .opcode        (req_opcode),
        .ra_data       (req_ra_data),
        .rb_data       (req_rb_data),
        .offset        (req_offset),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    //////////////////////////////////////////////////////////////////////
    // Output stage

    alu_dispatch u_alu_dispatch
    (
        .clock            (clock),
        .rst_n            (rst_n),
        .flush            (flush),
        .req_valid        (req_valid),
        .opcode           (req_opcode),
        .rd_addr          (req_rd_addr),
        .instr_id         (req_instr_id),
        .pc               (req_pc),
        .ra_data          (req_ra_data),
        .rb_data          (req_rb_data),
        .result           (result),
        .overflow         (overflow),
        .mem_addr         (mem_addr),
        .branch_taken     (branch_taken),
        .branch_target    (branch_target),
        .dcache_valid     (dcache_valid),
        .dcache_addr      (dcache_addr),
        .dcache_data      (dcache_data),
        .dcache_is_store  (dcache_is_store),
        .dcache_byte      (dcache_byte),
        .dcache_instr_id  (dcache_instr_id),
        .wb_valid         (wb_valid),
        .wb_instr_id      (wb_instr_id),
        .wb_pc            (wb_pc),
        .wb_rf_wen        (wb_rf_wen),
        .wb_rf_dest       (wb_rf_dest),
        .wb_rf_data       (wb_rf_data),
        .wb_xcpt_overflow (wb_xcpt_overflow),
        .take_branch      (take_branch),
        .branch_pc        (branch_pc)
    );

endmodule

/* sim/alu_props.sv */
`timescale 1ns/1ns

module alu_props
(
    input logic clock,
    input logic rst_n,
    input logic dcache_valid,
    input logic wb_valid,
    input logic take_branch
);

    // Each instruction takes exactly one route
    assert property (@(posedge clock) disable iff (!rst_n) !(dcache_valid && wb_valid))
        else $error("dcache_valid and wb_valid high together");

    // Redirects always retire through write-back
    assert property (@(posedge clock) disable iff (!rst_n) take_branch |-> wb_valid)
        else $error("take_branch without wb_valid");

    assert property (@(posedge clock) !rst_n |-> !(dcache_valid || wb_valid || take_branch))
        else $error("valid pulse high during reset");

endmodule

bind alu_top alu_props u_alu_props
(
    .clock        (clock),
    .rst_n        (rst_n),
    .dcache_valid (dcache_valid),
    .wb_valid     (wb_valid),
    .take_branch  (take_branch)
);

/* sim/alu_tb.sv */
`timescale 1ns/1ns

module alu_tb;

    import alu_pkg::*;

    localparam logic [31:0] SEED         = 32'h1df437c4;
    localparam int          RESET_CYCLES = 8;
    localparam int          IDLE_TIMEOUT = 10;

    // Stimulus kinds
    localparam int K_ARITH  = 0;
    localparam int K_OVF    = 1;
    localparam int K_MEM    = 2;
    localparam int K_BRANCH = 3;
    localparam int K_FLUSH  = 4;
    localparam int K_IDLE   = 5;

    logic      clock        = 1'b0;
    logic      rst_n        = 1'b0;
    logic      flush        = 1'b0;
    logic      req_valid    = 1'b0;
    opcode_e   req_opcode   = NOP;
    reg_addr_t req_rd_addr  = '0;
    data_t     req_ra_data  = '0;
    data_t     req_rb_data  = '0;
    offset_t   req_offset   = '0;
    pc_t       req_pc       = '0;
    instr_id_t req_instr_id = '0;

    logic      dcache_valid;
    data_t     dcache_addr;
    data_t     dcache_data;
    logic      dcache_is_store;
    logic      dcache_byte;
    instr_id_t dcache_instr_id;
    logic      wb_valid;
    instr_id_t wb_instr_id;
    pc_t       wb_pc;
    logic      wb_rf_wen;
    reg_addr_t wb_rf_dest;
    data_t     wb_rf_data;
    logic      wb_xcpt_overflow;
    logic      take_branch;
    pc_t       branch_pc;

    // Values for the next rising edge
    logic      next_rst_n = 1'b0;
    logic      next_flush = 1'b0;
    logic      next_valid = 1'b0;
    opcode_e   next_opcode = NOP;
    reg_addr_t next_rd_addr = '0;
    data_t     next_ra = '0;
    data_t     next_rb = '0;
    offset_t   next_offset = '0;
    pc_t       next_pc = '0;
    instr_id_t next_id = '0;

    // Model state, one request deep
    logic      exp_dc_valid = 1'b0;
    logic      exp_wb_valid = 1'b0;
    logic      exp_br       = 1'b0;
    data_t     exp_addr;
    data_t     exp_store_data;
    logic      exp_is_store;
    logic      exp_byte;
    instr_id_t exp_id;
    pc_t       exp_pc;
    logic      exp_wen;
    reg_addr_t exp_dest;
    data_t     exp_result;
    logic      exp_ovf;
    pc_t       exp_target;

    int err_count   = 0;
    int check_count = 0;

    opcode_e arith_ops  [8] = '{ADD, SUB, ADDI, SUBI, SLL, SRL, MOV, NOP};
    opcode_e mem_ops    [4] = '{LDW, LDB, STW, STB};
    opcode_e branch_ops [7] = '{BEQ, BNE, BLT, BGT, BLE, BGE, JUMP};

    alu_top u_alu_top (.*);

    always #20 clock = ~clock;

    always @(posedge clock)
    begin
        rst_n        <= next_rst_n;
        flush        <= next_flush;
        req_valid    <= next_valid;
        req_opcode   <= next_opcode;
        req_rd_addr  <= next_rd_addr;
        req_ra_data  <= next_ra;
        req_rb_data  <= next_rb;
        req_offset   <= next_offset;
        req_pc       <= next_pc;
        req_instr_id <= next_id;
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
        err_count++;
        $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, want);
    endtask

    task automatic check_dcache(input logic valid, input data_t addr, input data_t data,
                                input logic is_store, input logic byte_op,
                                input instr_id_t id);
        if (dcache_valid !== valid)
            report_mismatch("dcache_valid", 32'(dcache_valid), 32'(valid));
        else if (valid)
        begin
            if (dcache_addr !== addr)
                report_mismatch("dcache_addr", dcache_addr, addr);
            if (is_store && dcache_data !== data)
                report_mismatch("dcache_data", dcache_data, data);
            if (dcache_is_store !== is_store)
                report_mismatch("dcache_is_store", 32'(dcache_is_store), 32'(is_store));
            if (dcache_byte !== byte_op)
                report_mismatch("dcache_byte", 32'(dcache_byte), 32'(byte_op));
            if (dcache_instr_id !== id)
                report_mismatch("dcache_instr_id", 32'(dcache_instr_id), 32'(id));
        end
    endtask

    task automatic check_wb(input logic valid, input instr_id_t id, input pc_t pc,
                            input logic wen, input reg_addr_t dest, input data_t data,
                            input logic ovf);
        if (wb_valid !== valid)
            report_mismatch("wb_valid", 32'(wb_valid), 32'(valid));
        else if (valid)
        begin
            if (wb_instr_id !== id)
                report_mismatch("wb_instr_id", 32'(wb_instr_id), 32'(id));
            if (wb_pc !== pc)
                report_mismatch("wb_pc", wb_pc, pc);
            if (wb_rf_wen !== wen)
                report_mismatch("wb_rf_wen", 32'(wb_rf_wen), 32'(wen));
            if (wb_rf_dest !== dest)
                report_mismatch("wb_rf_dest", 32'(wb_rf_dest), 32'(dest));
            // Result only matters when it is written
            if (wen && wb_rf_data !== data)
                report_mismatch("wb_rf_data", wb_rf_data, data);
            if (wb_xcpt_overflow !== ovf)
                report_mismatch("wb_xcpt_overflow", 32'(wb_xcpt_overflow), 32'(ovf));
        end
    endtask

    task automatic check_branch(input logic taken, input pc_t target);
        if (take_branch !== taken)
            report_mismatch("take_branch", 32'(take_branch), 32'(taken));
        else if (taken && branch_pc !== target)
            report_mismatch("branch_pc", branch_pc, target);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model

    task automatic predict();
        logic [DATA_WIDTH:0]     wide;
        logic [2*DATA_WIDTH-1:0] shifted;
        data_t                   off_ext;
        data_t                   base;
        data_t                   res;
        logic                    ovf;
        logic                    is_mem;
        logic                    is_reg_op;
        logic                    taken;
        logic                    accept;

        off_ext      = data_t'(req_offset);
        res          = '0;
        ovf          = 1'b0;
        is_mem       = 1'b0;
        is_reg_op    = 1'b0;
        taken        = 1'b0;
        exp_is_store = (req_opcode == STW) || (req_opcode == STB);
        exp_byte     = (req_opcode == LDB) || (req_opcode == STB);
        base         = exp_is_store ? req_rb_data : req_ra_data;
        wide         = {1'b0, base} + {1'b0, off_ext};
        exp_addr     = wide[DATA_WIDTH-1:0];

        case (req_opcode)
            ADD:
            begin
                wide      = {1'b0, req_ra_data} + {1'b0, req_rb_data};
                res       = wide[DATA_WIDTH-1:0];
                ovf       = wide[DATA_WIDTH];
                is_reg_op = 1'b1;
            end
            ADDI:
            begin
                wide      = {1'b0, req_ra_data} + {1'b0, off_ext};
                res       = wide[DATA_WIDTH-1:0];
                ovf       = wide[DATA_WIDTH];
                is_reg_op = 1'b1;
            end
            SUB:
            begin
                res       = req_ra_data - req_rb_data;
                is_reg_op = 1'b1;
            end
            SUBI:
            begin
                res       = req_ra_data - off_ext;
                ovf       = req_ra_data < off_ext;
                is_reg_op = 1'b1;
            end
            SLL:
            begin
                // Shifts past the width lose every bit of ra
                if (req_offset > 16'd31)
                begin
                    res = '0;
                    ovf = |req_ra_data;
                end
                else
                begin
                    shifted = {{DATA_WIDTH{1'b0}}, req_ra_data} << req_offset;
                    res     = shifted[DATA_WIDTH-1:0];
                    ovf     = |shifted[2*DATA_WIDTH-1:DATA_WIDTH];
                end
                is_reg_op = 1'b1;
            end
            SRL:
            begin
                res       = req_ra_data >> req_offset;
                is_reg_op = 1'b1;
            end
            MOV:
            begin
                res       = req_ra_data;
                is_reg_op = 1'b1;
            end
            LDW, LDB, STW, STB:
            begin
                is_mem = 1'b1;
                ovf    = wide[DATA_WIDTH];
            end
            BEQ:     taken = req_ra_data == req_rb_data;
            BNE:     taken = req_ra_data != req_rb_data;
            BLT:     taken = req_ra_data < req_rb_data;
            BGT:     taken = req_ra_data > req_rb_data;
            BLE:     taken = req_ra_data <= req_rb_data;
            BGE:     taken = req_ra_data >= req_rb_data;
            JUMP:    taken = 1'b1;
            default: taken = 1'b0;
        endcase

        // Reset holds every pulse low
        accept         = rst_n && req_valid && !flush;
        exp_dc_valid   = accept && is_mem && !ovf;
        exp_wb_valid   = accept && !(is_mem && !ovf);
        exp_br         = accept && taken;
        exp_store_data = req_ra_data;
        exp_id         = req_instr_id;
        exp_pc         = req_pc;
        exp_wen        = is_reg_op && !ovf;
        exp_dest       = req_rd_addr;
        exp_result     = res;
        exp_ovf        = ovf;
        exp_target     = pc_t'(req_offset);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic gen_request(input int kind);
        logic [2:0] pick;
        int         r;
        opcode_e    op;
        data_t      ra;
        data_t      rb;
        offset_t    off;

        pick       = 3'($urandom % 8);
        r          = $urandom % 4;
        ra         = $urandom;
        rb         = $urandom;
        off        = offset_t'($urandom);
        next_valid = ($urandom % 8) != 0;
        next_flush = ($urandom % 16) == 0;

        case (kind)
            K_ARITH:
            begin
                op = arith_ops[pick];
                if (op == SLL || op == SRL)
                    off = offset_t'($urandom % 40);
            end
            K_OVF:
            begin
                case (r)
                    0:
                    begin
                        op = ADD;
                        ra = ra | 32'h8000_0000;
                        rb = rb | 32'h8000_0000;
                    end
                    1:
                    begin
                        op  = SUBI;
                        off = off | 16'h8000;
                        ra  = $urandom % data_t'(off);
                    end
                    2:
                    begin
                        op  = SLL;
                        ra  = ra | 32'h8000_0000;
                        off = offset_t'(1 + $urandom % 31);
                    end
                    default:
                    begin
                        // Base close to the top of the address space
                        op  = mem_ops[pick[1:0]];
                        off = off | 16'h8000;
                        ra  = ra | 32'hffff_8000;
                        rb  = rb | 32'hffff_8000;
                    end
                endcase
            end
            K_MEM:
            begin
                op = mem_ops[pick[1:0]];
                ra = ra & 32'h7fff_ffff;
                rb = rb & 32'h7fff_ffff;
            end
            K_BRANCH:
            begin
                // Small operands so equality comes up often
                op = branch_ops[3'($urandom % 7)];
                ra = $urandom % 4;
                rb = $urandom % 4;
                // Top bit now and then, where signed and unsigned order differ
                if (r == 0)
                    ra = ra | 32'h8000_0000;
                else if (r == 1)
                    rb = rb | 32'h8000_0000;
            end
            K_FLUSH:
            begin
                next_valid = r != 0;
                next_flush = r == 1;
                if (pick < 3'd3)
                    op = arith_ops[pick];
                else if (pick < 3'd6)
                    op = mem_ops[pick[1:0]];
                else
                    op = branch_ops[3'($urandom % 7)];
            end
            default:
            begin
                op         = NOP;
                next_valid = 1'b0;
                next_flush = 1'b0;
            end
        endcase

        next_opcode  = op;
        next_ra      = ra;
        next_rb      = rb;
        next_offset  = off;
        next_rd_addr = reg_addr_t'($urandom);
        next_pc      = $urandom;
        next_id      = instr_id_t'($urandom);
    endtask

    // Check last result, model the request now applied, pick the next one
    task automatic step(input int kind);
        @(negedge clock);
        check_count++;
        check_dcache(exp_dc_valid, exp_addr, exp_store_data, exp_is_store, exp_byte, exp_id);
        check_wb(exp_wb_valid, exp_id, exp_pc, exp_wen, exp_dest, exp_result, exp_ovf);
        check_branch(exp_br, exp_target);
        predict();
        gen_request(kind);
    endtask

    task automatic run_test(input int num, input string name, input int kind,
                            input int count);
        int errs_at_start;
        int n;

        errs_at_start = err_count;
        for (n = 0; n < count; n++)
            step(kind);
        // Two idle cycles drain the last request
        step(K_IDLE);
        step(K_IDLE);
        $display("Test %0d %s: %0d requests, %0d errors", num, name, count,
                 err_count - errs_at_start);
    endtask

    task automatic wait_outputs_idle(input int max_cycles, output logic idle);
        int n;

        idle = 1'b0;
        n    = 0;
        while (!idle && n < max_cycles)
        begin
            @(negedge clock);
            idle = !(dcache_valid || wb_valid || take_branch);
            n++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    initial
    begin
        logic idle;
        int   i;

        void'($urandom(SEED));

        // Requests keep coming during reset, pulses are checked low
        for (i = 0; i < RESET_CYCLES - 1; i++)
            step(K_FLUSH);
        step(K_IDLE);
        next_rst_n = 1'b1;
        wait_outputs_idle(IDLE_TIMEOUT, idle);
        $display("Test 0 reset: %0d errors", err_count);

        if (!idle)
            $display("Timeout: valid outputs did not go low after reset");
        else
        begin
            run_test(1, "arith", K_ARITH, 400);
            run_test(2, "overflow", K_OVF, 200);
            run_test(3, "memory", K_MEM, 300);
            run_test(4, "branch", K_BRANCH, 300);
            run_test(5, "flush", K_FLUSH, 200);
        end

        $display("Summary: %0d checks, %0d errors", check_count, err_count);
        if (idle && err_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* sources.f */
rtl/alu_pkg.sv
rtl/alu_datapath.sv
rtl/branch_resolve.sv
rtl/alu_dispatch.sv
rtl/alu_top.sv
sim/alu_props.sv
sim/alu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f --top-module alu_tb -Mdir obj_dir
then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Valu_tb)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
